// ==== Bender.yml ====
package:
  name: icache_array

sources:
  - icache_geom_pkg.sv
  - icache_entry_pkg.sv
  - sram_1rw.sv
  - idata_ram.sv
  - itag_ram.sv
  - icache_hit_sel.sv
  - icache_array.sv
  - target: test
    files:
      - tb_icache_array.sv

// ==== files.f ====
icache_geom_pkg.sv
icache_entry_pkg.sv
sram_1rw.sv
idata_ram.sv
itag_ram.sv
icache_hit_sel.sv
icache_array.sv
tb_icache_array.sv

// ==== icache_array.sv ====
`timescale 1ns/1ps

module icache_array (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                ic_en,
    input  logic [icache_geom_pkg::addr_w-1:0]  fetch_addr,
    input  logic                                ic_en_l2,
    input  logic                                data_wd_l2_en,
    input  logic                                block0_we_l2,
    input  logic                                block1_we_l2,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index_l2,
    input  icache_entry_pkg::tag_t              tag_l2,
    input  logic [icache_geom_pkg::line_w-1:0]  data_wd_l2,
    input  logic                                ic_en_mem,
    input  logic                                data_wd_mem_en,
    input  logic                                block0_we_mem,
    input  logic                                block1_we_mem,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index_mem,
    input  icache_entry_pkg::tag_t              tag_mem,
    input  logic [icache_geom_pkg::line_w-1:0]  data_wd_mem,
    output logic                                lookup_done,
    output logic                                hit,
    output logic                                hit_way,
    output logic [icache_geom_pkg::word_w-1:0]  instr
);

    localparam int word_lsb  = icache_geom_pkg::byte_w;
    localparam int index_lsb = word_lsb + icache_geom_pkg::word_sel_w;

    icache_entry_pkg::tag_t                     lookup_tag;
    logic [icache_geom_pkg::index_w-1:0]        lookup_index;
    logic [icache_geom_pkg::word_sel_w-1:0]     lookup_word;
    logic                                       lookup_go;
    icache_entry_pkg::tag_t                     tag0_rd;
    icache_entry_pkg::tag_t                     tag1_rd;
    logic                                       valid0_rd;
    logic                                       valid1_rd;
    logic [icache_geom_pkg::line_w-1:0]         data0_rd;
    logic [icache_geom_pkg::line_w-1:0]         data1_rd;

    assign lookup_tag   = fetch_addr[icache_geom_pkg::addr_w-1 -: icache_geom_pkg::tag_w];
    assign lookup_index = fetch_addr[index_lsb +: icache_geom_pkg::index_w];
    assign lookup_word  = fetch_addr[word_lsb +: icache_geom_pkg::word_sel_w];

    // a refill owns the arrays, the lookup has to come back
    assign lookup_go = ic_en && icache_entry_pkg::pick_src(ic_en_l2, data_wd_l2_en,
                                                           ic_en_mem, data_wd_mem_en)
                                == icache_entry_pkg::src_none;

    itag_ram u_itag_ram (
        .clk            (clk),
        .arst_n         (arst_n),
        .ic_en          (ic_en),
        .block0_re      (lookup_go),
        .block1_re      (lookup_go),
        .ic_index       (lookup_index),
        .ic_en_l2       (ic_en_l2),
        .data_wd_l2_en  (data_wd_l2_en),
        .block0_we_l2   (block0_we_l2),
        .block1_we_l2   (block1_we_l2),
        .ic_index_l2    (ic_index_l2),
        .tag_l2         (tag_l2),
        .ic_en_mem      (ic_en_mem),
        .data_wd_mem_en (data_wd_mem_en),
        .block0_we_mem  (block0_we_mem),
        .block1_we_mem  (block1_we_mem),
        .ic_index_mem   (ic_index_mem),
        .tag_mem        (tag_mem),
        .tag0_rd        (tag0_rd),
        .tag1_rd        (tag1_rd),
        .valid0_rd      (valid0_rd),
        .valid1_rd      (valid1_rd)
    );

    idata_ram u_idata_ram (
        .clk            (clk),
        .ic_en          (ic_en),
        .block0_re      (lookup_go),
        .block1_re      (lookup_go),
        .ic_index       (lookup_index),
        .ic_en_l2       (ic_en_l2),
        .data_wd_l2_en  (data_wd_l2_en),
        .block0_we_l2   (block0_we_l2),
        .block1_we_l2   (block1_we_l2),
        .ic_index_l2    (ic_index_l2),
        .data_wd_l2     (data_wd_l2),
        .ic_en_mem      (ic_en_mem),
        .data_wd_mem_en (data_wd_mem_en),
        .block0_we_mem  (block0_we_mem),
        .block1_we_mem  (block1_we_mem),
        .ic_index_mem   (ic_index_mem),
        .data_wd_mem    (data_wd_mem),
        .data0_rd       (data0_rd),
        .data1_rd       (data1_rd)
    );

    icache_hit_sel u_hit_sel (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_go   (lookup_go),
        .lookup_tag  (lookup_tag),
        .lookup_word (lookup_word),
        .tag0_rd     (tag0_rd),
        .tag1_rd     (tag1_rd),
        .valid0_rd   (valid0_rd),
        .valid1_rd   (valid1_rd),
        .data0_rd    (data0_rd),
        .data1_rd    (data1_rd),
        .lookup_done (lookup_done),
        .hit         (hit),
        .hit_way     (hit_way),
        .instr       (instr)
    );

endmodule

// ==== icache_entry_pkg.sv ====
package icache_entry_pkg;

    localparam int way_count = 2;

    typedef logic [icache_geom_pkg::tag_w-1:0] tag_t;

    // which refill port owns the arrays this cycle
    typedef enum logic [1:0] {
        src_none = 2'd0,
        src_l2   = 2'd1,
        src_mem  = 2'd2
    } refill_src_t;

    // l2 wins over memory, a port needs both its enables
    function automatic refill_src_t pick_src(
        input logic en_l2,
        input logic wd_l2_en,
        input logic en_mem,
        input logic wd_mem_en
    );
        if (en_l2 && wd_l2_en) begin
            return src_l2;
        end else if (en_mem && wd_mem_en) begin
            return src_mem;
        end
        return src_none;
    endfunction

endpackage

// ==== icache_geom_pkg.sv ====
package icache_geom_pkg;

    // fetch address layout: tag | index | word select | byte
    localparam int addr_w      = 32;
    localparam int byte_w      = 2;    // byte offset inside a word
    localparam int word_sel_w  = 2;    // word inside a line
    localparam int index_w     = 8;    // set index
    localparam int tag_w       = addr_w - index_w - word_sel_w - byte_w;

    localparam int set_count   = 2 ** index_w;

    // one line per way
    localparam int word_w        = 32;
    localparam int line_w        = word_w * (2 ** word_sel_w);
    localparam int banks_per_way = line_w / word_w;    // one ram bank per word

endpackage

// ==== icache_hit_sel.sv ====
`timescale 1ns/1ps

module icache_hit_sel (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   lookup_go,
    input  icache_entry_pkg::tag_t                 lookup_tag,
    input  logic [icache_geom_pkg::word_sel_w-1:0] lookup_word,
    input  icache_entry_pkg::tag_t                 tag0_rd,
    input  icache_entry_pkg::tag_t                 tag1_rd,
    input  logic                                   valid0_rd,
    input  logic                                   valid1_rd,
    input  logic [icache_geom_pkg::line_w-1:0]     data0_rd,
    input  logic [icache_geom_pkg::line_w-1:0]     data1_rd,
    output logic                                   lookup_done,
    output logic                                   hit,
    output logic                                   hit_way,
    output logic [icache_geom_pkg::word_w-1:0]     instr
);

    icache_entry_pkg::tag_t                        tag_q;
    logic [icache_geom_pkg::word_sel_w-1:0]        word_q;
    logic                                          match0;
    logic                                          match1;
    logic [icache_geom_pkg::line_w-1:0]            line;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_done <= 1'b0;
        end else begin
            lookup_done <= lookup_go;    // ram data lands the same cycle
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_go) begin
            tag_q  <= lookup_tag;
            word_q <= lookup_word;
        end
    end

    assign match0  = valid0_rd && (tag0_rd == tag_q);
    assign match1  = valid1_rd && (tag1_rd == tag_q);
    assign hit     = lookup_done && (match0 || match1);
    assign hit_way = !match0 && match1;    // way 0 wins a double match

    always_comb begin
        line  = hit_way ? data1_rd : data0_rd;
        instr = '0;
        if (hit) begin
            instr = line[word_q*icache_geom_pkg::word_w +: icache_geom_pkg::word_w];
        end
    end

endmodule

// ==== icache_testdata.txt ====
# name op way addr line hit hway instr (hex, refills ignore the last three, lookups the line)
# both: l2 side as given, memory side with inverted tag and inverted line
rst_miss_0     look      0 00000000 0 0 0 00000000
rst_miss_1     look      0 12345670 0 0 0 00000000
rst_miss_2     look      0 fffffffc 0 0 0 00000000
rst_miss_3     look      0 abcde3c0 0 0 0 00000000
fill_l2_w0     rl2       0 abcde3c0 4444aaaa3333aaaa2222aaaa1111aaaa 0 0 00000000
fill_mem_w1    rmem      1 123453c0 4444bbbb3333bbbb2222bbbb1111bbbb 0 0 00000000
w0_word0       look      0 abcde3c0 0 1 0 1111aaaa
w0_word1       look      0 abcde3c4 0 1 0 2222aaaa
w0_word2       look      0 abcde3c8 0 1 0 3333aaaa
w0_word3       look      0 abcde3cc 0 1 0 4444aaaa
w1_word0       look      0 123453c0 0 1 1 1111bbbb
w1_word1       look      0 123453c4 0 1 1 2222bbbb
w1_word2       look      0 123453c8 0 1 1 3333bbbb
w1_word3       look      0 123453cc 0 1 1 4444bbbb
other_tag      look      0 555553c0 0 0 0 00000000
both_fill      both      0 0badc4a0 8888cccc7777cccc6666cccc5555cccc 0 0 00000000
both_l2_hit    look      0 0badc4a4 0 1 0 6666cccc
both_l2_hit_3  look      0 0badc4ac 0 1 0 8888cccc
both_mem_miss  look      0 f45234a0 0 0 0 00000000
both_mem_miss3 look      0 f45234ac 0 0 0 00000000
nowd_l2        rl2_nowd  1 0f0f05b0 0123456789abcdef0123456789abcdef 0 0 00000000
noen_l2        rl2_noen  0 0f0f15b0 fedcba9876543210fedcba9876543210 0 0 00000000
nowd_mem       rmem_nowd 1 0e0e05c0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 0 00000000
noen_mem       rmem_noen 0 0e0e15c0 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 0 00000000
nowd_l2_chk    look      0 0f0f05b0 0 0 0 00000000
noen_l2_chk    look      0 0f0f15b0 0 0 0 00000000
nowd_mem_chk   look      0 0e0e05c0 0 0 0 00000000
noen_mem_chk   look      0 0e0e15c0 0 0 0 00000000
collide        lkrf      1 7777a700 4444dddd3333dddd2222dddd1111dddd 0 0 00000000
after_collide  lookb     0 7777a708 0 1 1 3333dddd
b2b_0          look      0 abcde3c0 0 1 0 1111aaaa
b2b_1          lookb     0 123453cc 0 1 1 4444bbbb
b2b_2          lookb     0 555553c0 0 0 0 00000000
b2b_3          lookb     0 abcde3c8 0 1 0 3333aaaa
b2b_4          lookb     0 7777a704 0 1 1 2222dddd
b2b_5          lookb     0 0badc4a0 0 1 0 5555cccc

// ==== idata_ram.sv ====
`timescale 1ns/1ps

module idata_ram (
    input  logic                                clk,
    input  logic                                ic_en,
    input  logic                                block0_re,
    input  logic                                block1_re,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index,
    input  logic                                ic_en_l2,
    input  logic                                data_wd_l2_en,
    input  logic                                block0_we_l2,
    input  logic                                block1_we_l2,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index_l2,
    input  logic [icache_geom_pkg::line_w-1:0]  data_wd_l2,
    input  logic                                ic_en_mem,
    input  logic                                data_wd_mem_en,
    input  logic                                block0_we_mem,
    input  logic                                block1_we_mem,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index_mem,
    input  logic [icache_geom_pkg::line_w-1:0]  data_wd_mem,
    output logic [icache_geom_pkg::line_w-1:0]  data0_rd,
    output logic [icache_geom_pkg::line_w-1:0]  data1_rd
);

    localparam int word_w = icache_geom_pkg::word_w;

    icache_entry_pkg::refill_src_t              src;
    logic [icache_geom_pkg::index_w-1:0]        index;
    logic [icache_geom_pkg::line_w-1:0]         data_wd;
    logic [icache_entry_pkg::way_count-1:0]     we;
    logic [icache_entry_pkg::way_count-1:0]     re;
    logic [icache_entry_pkg::way_count-1:0][icache_geom_pkg::line_w-1:0] rd;

    // refill port mux, lookup index when nobody writes
    always_comb begin
        src     = icache_entry_pkg::pick_src(ic_en_l2, data_wd_l2_en,
                                             ic_en_mem, data_wd_mem_en);
        index   = ic_index;
        data_wd = data_wd_l2;
        we      = '0;
        case (src)
            icache_entry_pkg::src_l2: begin
                index = ic_index_l2;
                we    = {block1_we_l2, block0_we_l2};
            end
            icache_entry_pkg::src_mem: begin
                index   = ic_index_mem;
                data_wd = data_wd_mem;
                we      = {block1_we_mem, block0_we_mem};
            end
            default: ;
        endcase
    end

    // never read a bank while it is being refilled
    assign re = {block1_re, block0_re}
              & {icache_entry_pkg::way_count{ic_en && src == icache_entry_pkg::src_none}};

    for (genvar w = 0; w < icache_entry_pkg::way_count; w++) begin : g_way
        for (genvar b = 0; b < icache_geom_pkg::banks_per_way; b++) begin : g_bank
            sram_1rw #(
                .word_t (logic [word_w-1:0]),
                .depth  (icache_geom_pkg::set_count)
            ) u_bank (
                .clk     (clk),
                .address (index),
                .wren    (we[w]),
                .rden    (re[w]),
                .data    (data_wd[b*word_w +: word_w]),    // word b of the line
                .q       (rd[w][b*word_w +: word_w])
            );
        end
    end

    assign data0_rd = rd[0];
    assign data1_rd = rd[1];

endmodule

// ==== itag_ram.sv ====
`timescale 1ns/1ps

module itag_ram (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                ic_en,
    input  logic                                block0_re,
    input  logic                                block1_re,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index,
    input  logic                                ic_en_l2,
    input  logic                                data_wd_l2_en,
    input  logic                                block0_we_l2,
    input  logic                                block1_we_l2,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index_l2,
    input  icache_entry_pkg::tag_t              tag_l2,
    input  logic                                ic_en_mem,
    input  logic                                data_wd_mem_en,
    input  logic                                block0_we_mem,
    input  logic                                block1_we_mem,
    input  logic [icache_geom_pkg::index_w-1:0] ic_index_mem,
    input  icache_entry_pkg::tag_t              tag_mem,
    output icache_entry_pkg::tag_t              tag0_rd,
    output icache_entry_pkg::tag_t              tag1_rd,
    output logic                                valid0_rd,
    output logic                                valid1_rd
);

    icache_entry_pkg::refill_src_t              src;
    logic [icache_geom_pkg::index_w-1:0]        index;
    icache_entry_pkg::tag_t                     tag_wd;
    logic [icache_entry_pkg::way_count-1:0]     we;
    logic [icache_entry_pkg::way_count-1:0]     re;
    icache_entry_pkg::tag_t                     tag_rd [icache_entry_pkg::way_count];
    logic [icache_entry_pkg::way_count-1:0][icache_geom_pkg::set_count-1:0] valid_q;
    logic [icache_entry_pkg::way_count-1:0]     valid_rd_q;

    always_comb begin
        src    = icache_entry_pkg::pick_src(ic_en_l2, data_wd_l2_en,
                                            ic_en_mem, data_wd_mem_en);
        index  = ic_index;
        tag_wd = tag_l2;
        we     = '0;
        case (src)
            icache_entry_pkg::src_l2: begin
                index = ic_index_l2;
                we    = {block1_we_l2, block0_we_l2};
            end
            icache_entry_pkg::src_mem: begin
                index  = ic_index_mem;
                tag_wd = tag_mem;
                we     = {block1_we_mem, block0_we_mem};
            end
            default: ;
        endcase
    end

    assign re = {block1_re, block0_re}
              & {icache_entry_pkg::way_count{ic_en && src == icache_entry_pkg::src_none}};

    for (genvar w = 0; w < icache_entry_pkg::way_count; w++) begin : g_way
        sram_1rw #(
            .word_t (icache_entry_pkg::tag_t),
            .depth  (icache_geom_pkg::set_count)
        ) u_tag (
            .clk     (clk),
            .address (index),
            .wren    (we[w]),
            .rden    (re[w]),
            .data    (tag_wd),
            .q       (tag_rd[w])
        );

        // valid bits live in flops so reset can clear the whole way
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q[w]    <= '0;
                valid_rd_q[w] <= 1'b0;
            end else begin
                if (we[w]) begin
                    valid_q[w][index] <= 1'b1;
                end
                if (re[w]) begin
                    valid_rd_q[w] <= valid_q[w][index];    // same latency as the tag
                end
            end
        end
    end

    assign tag0_rd   = tag_rd[0];
    assign tag1_rd   = tag_rd[1];
    assign valid0_rd = valid_rd_q[0];
    assign valid1_rd = valid_rd_q[1];

endmodule

// ==== sram_1rw.sv ====
`timescale 1ns/1ps

module sram_1rw #(
    parameter type word_t = logic [31:0],
    parameter int  depth  = 256
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] address,
    input  logic                     wren,
    input  logic                     rden,
    input  word_t                    data,
    output word_t                    q
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
    end

    // registered read, q holds while rden is low
    always_ff @(posedge clk) begin
        if (rden) begin
            q <= mem[address];    // old data on a same-address write
        end
    end

endmodule

// ==== tb_icache_array.sv ====
`timescale 1ns/1ps

module tb_icache_array;

    localparam int max_ops = 64;

    logic         clk;
    logic         arst_n;
    logic         ic_en;
    logic [31:0]  fetch_addr;
    logic         ic_en_l2;
    logic         data_wd_l2_en;
    logic         block0_we_l2;
    logic         block1_we_l2;
    logic [7:0]   ic_index_l2;
    logic [19:0]  tag_l2;
    logic [127:0] data_wd_l2;
    logic         ic_en_mem;
    logic         data_wd_mem_en;
    logic         block0_we_mem;
    logic         block1_we_mem;
    logic [7:0]   ic_index_mem;
    logic [19:0]  tag_mem;
    logic [127:0] data_wd_mem;
    logic         lookup_done;
    logic         hit;
    logic         hit_way;
    logic [31:0]  instr;

    string        op_name   [max_ops];
    string        op_code   [max_ops];
    logic         op_way    [max_ops];
    logic [31:0]  op_addr   [max_ops];
    logic [127:0] op_line   [max_ops];
    logic         exp_hit   [max_ops];
    logic         exp_way   [max_ops];
    logic [31:0]  exp_instr [max_ops];
    int           n_ops;

    int           due_q [$];    // cycle where a result must be seen
    int           idx_q [$];    // op the result belongs to
    int           cyc = 0;
    int           cyc_limit = 100000;
    int           errors = 0;
    int           checked = 0;
    int           cur;
    int           cur_due;
    bit           ok;

    icache_array UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .ic_en          (ic_en),
        .fetch_addr     (fetch_addr),
        .ic_en_l2       (ic_en_l2),
        .data_wd_l2_en  (data_wd_l2_en),
        .block0_we_l2   (block0_we_l2),
        .block1_we_l2   (block1_we_l2),
        .ic_index_l2    (ic_index_l2),
        .tag_l2         (tag_l2),
        .data_wd_l2     (data_wd_l2),
        .ic_en_mem      (ic_en_mem),
        .data_wd_mem_en (data_wd_mem_en),
        .block0_we_mem  (block0_we_mem),
        .block1_we_mem  (block1_we_mem),
        .ic_index_mem   (ic_index_mem),
        .tag_mem        (tag_mem),
        .data_wd_mem    (data_wd_mem),
        .lookup_done    (lookup_done),
        .hit            (hit),
        .hit_way        (hit_way),
        .instr          (instr)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;    // 40 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display("timeout after %0d cycles, %0d errors so far", cyc, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic set_idle();
        ic_en          = 1'b0;
        fetch_addr     = '0;
        ic_en_l2       = 1'b0;
        data_wd_l2_en  = 1'b0;
        block0_we_l2   = 1'b0;
        block1_we_l2   = 1'b0;
        ic_index_l2    = '0;
        tag_l2         = '0;
        data_wd_l2     = '0;
        ic_en_mem      = 1'b0;
        data_wd_mem_en = 1'b0;
        block0_we_mem  = 1'b0;
        block1_we_mem  = 1'b0;
        ic_index_mem   = '0;
        tag_mem        = '0;
        data_wd_mem    = '0;
    endtask

    // address split: tag [31:12], index [11:4]
    task automatic drive_l2(input logic way, input logic [31:0] addr,
                            input logic [127:0] line, input logic en, input logic wd_en);
        ic_en_l2      = en;
        data_wd_l2_en = wd_en;
        block0_we_l2  = !way;
        block1_we_l2  = way;
        ic_index_l2   = addr[11:4];
        tag_l2        = addr[31:12];
        data_wd_l2    = line;
    endtask

    task automatic drive_mem(input logic way, input logic [31:0] addr,
                             input logic [127:0] line, input logic en, input logic wd_en);
        ic_en_mem      = en;
        data_wd_mem_en = wd_en;
        block0_we_mem  = !way;
        block1_we_mem  = way;
        ic_index_mem   = addr[11:4];
        tag_mem        = addr[31:12];
        data_wd_mem    = line;
    endtask

    task automatic drive_lookup(input int i);
        ic_en      = 1'b1;
        fetch_addr = op_addr[i];
        due_q.push_back(cyc + 1);    // accepted at the next edge
        idx_q.push_back(i);
    endtask

    task automatic check_result(input int i, input int due);
        checked++;
        assert (lookup_done) else begin
            $display("lookup %s produced no result in cycle %0d", op_name[i], due);
            errors++;
        end
        if (lookup_done) begin
            assert (hit === exp_hit[i]) else begin
                $display("error %s hit expected %0b actual %0b", op_name[i], exp_hit[i], hit);
                errors++;
            end
            if (exp_hit[i]) begin
                assert (hit_way === exp_way[i]) else begin
                    $display("error %s way expected %0b actual %0b",
                             op_name[i], exp_way[i], hit_way);
                    errors++;
                end
            end
            assert (instr === exp_instr[i]) else begin
                $display("error %s instr expected %h actual %h",
                         op_name[i], exp_instr[i], instr);
                errors++;
            end
        end
    endtask

    // outputs settle from registers long before the falling edge
    always @(negedge clk) begin
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            cur     = idx_q.pop_front();
            cur_due = due_q.pop_front();
            check_result(cur, cur_due);
        end else begin
            assert (!lookup_done) else begin
                $display("lookup_done rose in cycle %0d with no accepted lookup", cyc);
                errors++;
            end
        end
    end

    task automatic load_testdata(output bit loaded);
        int               fd;
        int               cnt;
        logic [8*160-1:0] text;
        string            nm;
        string            code;
        logic [31:0]      way_v;
        logic [31:0]      addr_v;
        logic [127:0]     line_v;
        logic [31:0]      hit_v;
        logic [31:0]      hway_v;
        logic [31:0]      instr_v;
        loaded = 1'b0;
        n_ops  = 0;
        fd     = $fopen("icache_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_ops < max_ops) begin
                text = '0;
                if ($fgets(text, fd) > 0) begin
                    cnt = $sscanf(text, "%s %s %h %h %h %h %h %h", nm, code,
                                  way_v, addr_v, line_v, hit_v, hway_v, instr_v);
                    if (cnt == 8 && nm[0] != "#") begin    // header lines fail the parse
                        op_name[n_ops]   = nm;
                        op_code[n_ops]   = code;
                        op_way[n_ops]    = way_v[0];
                        op_addr[n_ops]   = addr_v;
                        op_line[n_ops]   = line_v;
                        exp_hit[n_ops]   = hit_v[0];
                        exp_way[n_ops]   = hway_v[0];
                        exp_instr[n_ops] = instr_v;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
            loaded    = (n_ops > 0);
            cyc_limit = 8 * n_ops + 50;
        end
    endtask

    task automatic run_op(input int i);
        int gap;
        gap = (op_code[i] == "lookb") ? 0 : $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #2;
            set_idle();
        end
        @(posedge clk);
        #2;
        set_idle();
        if (op_code[i] == "rl2") begin
            drive_l2(op_way[i], op_addr[i], op_line[i], 1'b1, 1'b1);
        end else if (op_code[i] == "rmem") begin
            drive_mem(op_way[i], op_addr[i], op_line[i], 1'b1, 1'b1);
        end else if (op_code[i] == "both") begin
            drive_l2(op_way[i], op_addr[i], op_line[i], 1'b1, 1'b1);
            drive_mem(op_way[i], {~op_addr[i][31:12], op_addr[i][11:0]}, ~op_line[i],
                      1'b1, 1'b1);    // memory side with its own tag
        end else if (op_code[i] == "rl2_nowd") begin
            drive_l2(op_way[i], op_addr[i], op_line[i], 1'b1, 1'b0);
        end else if (op_code[i] == "rl2_noen") begin
            drive_l2(op_way[i], op_addr[i], op_line[i], 1'b0, 1'b1);
        end else if (op_code[i] == "rmem_nowd") begin
            drive_mem(op_way[i], op_addr[i], op_line[i], 1'b1, 1'b0);
        end else if (op_code[i] == "rmem_noen") begin
            drive_mem(op_way[i], op_addr[i], op_line[i], 1'b0, 1'b1);
        end else if (op_code[i] == "lkrf") begin
            drive_l2(op_way[i], op_addr[i], op_line[i], 1'b1, 1'b1);
            ic_en      = 1'b1;    // refused, so no result expected
            fetch_addr = op_addr[i];
        end else if (op_code[i] == "look" || op_code[i] == "lookb") begin
            drive_lookup(i);
        end else begin
            $display("unknown op %s on test line %s", op_code[i], op_name[i]);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h7d37_2ebf));
        arst_n = 1'b0;
        set_idle();
        load_testdata(ok);
        if (!ok) begin
            $display("test data in icache_testdata.txt could not be read");
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            #2;
            arst_n = 1'b1;
            for (int i = 0; i < n_ops; i++) begin
                run_op(i);
            end
            @(posedge clk);
            #2;
            set_idle();
            while (due_q.size() > 0) begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);    // catch a stray lookup_done
            $display("errors: %0d, lookups checked: %0d", errors, checked);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule
